//--- common/cacheCfgPkg.sv
package cacheCfgPkg;

  ////////////////////////////////////////
  // geometry
  ////////////////////////////////////////

  localparam int NUM_WAYS       = 4;
  localparam int NUM_SETS       = 16;
  localparam int WORDS_PER_LINE = 4;

  // address split: tag | index | word | byte
  localparam int OFFSET_W   = 2;
  localparam int WORD_SEL_W = 2;
  localparam int INDEX_W    = 4;
  localparam int TAG_W      = 24;

  ////////////////////////////////////////
  // vector types
  ////////////////////////////////////////

  typedef logic [31:0] addrT;              // byte address
  typedef logic [31:0] wordT;

  typedef logic [TAG_W-1:0]      tagT;      // addr[31:8]
  typedef logic [INDEX_W-1:0]    indexT;    // addr[7:4]
  typedef logic [WORD_SEL_W-1:0] wordSelT;  // addr[3:2]

  typedef logic [3:0] byteEnT;             // one bit per byte lane

  typedef logic [1:0]          wayT;
  typedef logic [NUM_WAYS-1:0] wayVecT;

  // 0 is most recently used
  typedef logic [1:0] ageT;

  // what goes out on the memory port
  typedef logic [TAG_W+INDEX_W-1:0] lineAddrT;

endpackage

//--- common/cacheBusPkg.sv
package cacheBusPkg;

  ////////////////////////////////////////
  // cpu side
  ////////////////////////////////////////

  // held stable until done
  typedef struct packed {
    logic                valid;
    logic                write;
    cacheCfgPkg::addrT   addr;
    cacheCfgPkg::wordT   wdata;
    cacheCfgPkg::byteEnT byteEn;
  } cpuReqT;

  typedef struct packed {
    logic              done;   // one cycle pulse
    cacheCfgPkg::wordT rdata;  // valid with done on reads
  } cpuRespT;

  ////////////////////////////////////////
  // memory side
  ////////////////////////////////////////

  // four beats per line, word 0 first
  typedef struct packed {
    logic                  valid;
    logic                  write;
    cacheCfgPkg::lineAddrT lineAddr;
    cacheCfgPkg::wordT     wdata;
  } memReqT;

  typedef struct packed {
    logic              ready;  // beat moves on valid and ready
    cacheCfgPkg::wordT rdata;
  } memRespT;

endpackage

//--- cacheArray/wayStore.sv
`timescale 1ns/1ps

module wayStore (
  input  logic                 clk,
  input  logic                 addr_ok,
  input  cacheCfgPkg::indexT   index,
  input  cacheCfgPkg::tagT     lookupTag,
  input  cacheCfgPkg::wordSelT wordSel,
  input  logic                 wordWrEn,
  input  cacheCfgPkg::byteEnT  byteEn,
  input  cacheCfgPkg::wordT    wrData,
  input  logic                 markDirty,
  input  logic                 installEn,
  output logic                 hit,
  output logic                 lineValid,
  output logic                 lineDirty,
  output cacheCfgPkg::tagT     storedTag,
  output cacheCfgPkg::wordT    rdata
);

  cacheCfgPkg::tagT  tagMem  [cacheCfgPkg::NUM_SETS];
  cacheCfgPkg::wordT dataMem [cacheCfgPkg::NUM_SETS][cacheCfgPkg::WORDS_PER_LINE];

  logic [cacheCfgPkg::NUM_SETS-1:0] validBits;
  logic [cacheCfgPkg::NUM_SETS-1:0] dirtyBits;

  // async reads straight from the arrays
  assign storedTag = tagMem[index];
  assign lineValid = validBits[index];
  assign lineDirty = dirtyBits[index];
  assign rdata     = dataMem[index][wordSel];

  assign hit = lineValid && (storedTag == lookupTag);

  // line state
  always_ff @(posedge clk or posedge addr_ok) begin
    if (addr_ok) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else begin
      if (installEn) begin
        validBits[index] <= 1'b1;
        dirtyBits[index] <= 1'b0;  // fresh line from memory
      end
      if (markDirty) begin
        dirtyBits[index] <= 1'b1;
      end
    end
  end

  // tag and data
  always_ff @(posedge clk) begin
    if (installEn) begin
      tagMem[index] <= lookupTag;
    end
    if (wordWrEn) begin
      for (int b = 0; b < $bits(cacheCfgPkg::byteEnT); b++) begin
        if (byteEn[b]) begin
          dataMem[index][wordSel][8*b +: 8] <= wrData[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- cacheArray/lruTracker.sv
`timescale 1ns/1ps

module lruTracker (
  input  logic                clk,
  input  logic                addr_ok,
  input  cacheCfgPkg::indexT  index,
  input  cacheCfgPkg::wayVecT wayValid,
  input  logic                touchEn,
  input  cacheCfgPkg::wayT    touchWay,
  output cacheCfgPkg::wayT    victimWay
);

  cacheCfgPkg::ageT ages [cacheCfgPkg::NUM_SETS][cacheCfgPkg::NUM_WAYS];
  cacheCfgPkg::ageT touchedAge;

  assign touchedAge = ages[index][touchWay];

  // touched way goes to 0, ways not older than it move up one.
  // untouched ways share the top age, so this never wraps
  always_ff @(posedge clk or posedge addr_ok) begin
    if (addr_ok) begin
      for (int s = 0; s < cacheCfgPkg::NUM_SETS; s++) begin
        for (int w = 0; w < cacheCfgPkg::NUM_WAYS; w++) begin
          ages[s][w] <= '0;
        end
      end
    end else if (touchEn) begin
      for (int w = 0; w < cacheCfgPkg::NUM_WAYS; w++) begin
        if (cacheCfgPkg::wayT'(w) == touchWay) begin
          ages[index][w] <= '0;
        end else if (ages[index][w] <= touchedAge) begin
          ages[index][w] <= cacheCfgPkg::ageT'(ages[index][w] + 1'b1);
        end
      end
    end
  end

  // first free way, else oldest (low number on a tie)
  always_comb begin
    logic             found;
    cacheCfgPkg::ageT oldest;
    found     = 1'b0;
    oldest    = '0;
    victimWay = '0;
    for (int w = 0; w < cacheCfgPkg::NUM_WAYS; w++) begin
      if (!found && !wayValid[w]) begin
        victimWay = cacheCfgPkg::wayT'(w);
        found     = 1'b1;
      end
    end
    if (!found) begin
      for (int w = 0; w < cacheCfgPkg::NUM_WAYS; w++) begin
        if (ages[index][w] > oldest) begin
          oldest    = ages[index][w];
          victimWay = cacheCfgPkg::wayT'(w);
        end
      end
    end
  end

endmodule

//--- logic/cacheCtrl.sv
`timescale 1ns/1ps

module cacheCtrl (
  input  logic                 clk,
  input  logic                 addr_ok,
  input  cacheBusPkg::cpuReqT  cpuReq,
  output cacheBusPkg::cpuRespT cpuResp,
  output cacheBusPkg::memReqT  memReq,
  input  cacheBusPkg::memRespT memResp,
  output cacheCfgPkg::indexT   index,
  output cacheCfgPkg::tagT     lookupTag,
  output cacheCfgPkg::wordSelT wordSel,
  input  cacheCfgPkg::wayVecT  wayHit,
  input  cacheCfgPkg::wayVecT  wayValid,
  input  cacheCfgPkg::wayVecT  wayDirty,
  input  cacheCfgPkg::tagT     wayTags [cacheCfgPkg::NUM_WAYS],
  input  cacheCfgPkg::wordT    wayData [cacheCfgPkg::NUM_WAYS],
  output cacheCfgPkg::wayVecT  wordWrEn,
  output cacheCfgPkg::byteEnT  byteEn,
  output cacheCfgPkg::wordT    wrData,
  output cacheCfgPkg::wayVecT  markDirty,
  output cacheCfgPkg::wayVecT  installEn,
  output logic                 touchEn,
  output cacheCfgPkg::wayT     touchWay,
  input  cacheCfgPkg::wayT     victimWay
);

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILL,
    COMPLETE
  } ctrlStateT;

  ctrlStateT            state;
  ctrlStateT            nextState;
  cacheBusPkg::cpuReqT  req;       // request in flight
  cacheCfgPkg::wayT     wayReg;    // victim chosen in LOOKUP
  cacheCfgPkg::wayT     hitWay;
  cacheCfgPkg::wayT     selWay;
  cacheCfgPkg::wordSelT beatCnt;
  logic                 anyHit;
  logic                 inXfer;
  logic                 beatAcc;
  logic                 lastBeat;

  ////////////////////////////////////////
  // address and way select
  ////////////////////////////////////////

  assign lookupTag = req.addr[cacheCfgPkg::OFFSET_W + cacheCfgPkg::WORD_SEL_W
                              + cacheCfgPkg::INDEX_W +: cacheCfgPkg::TAG_W];
  assign index     = req.addr[cacheCfgPkg::OFFSET_W + cacheCfgPkg::WORD_SEL_W
                              +: cacheCfgPkg::INDEX_W];

  assign inXfer   = (state == WRITEBACK) || (state == REFILL);
  assign beatAcc  = inXfer && memResp.ready;
  assign lastBeat = beatCnt == cacheCfgPkg::wordSelT'(cacheCfgPkg::WORDS_PER_LINE - 1);

  // beat count while moving a line, cpu word otherwise
  assign wordSel = inXfer ? beatCnt
                          : req.addr[cacheCfgPkg::OFFSET_W +: cacheCfgPkg::WORD_SEL_W];

  always_comb begin
    hitWay = '0;
    for (int w = 0; w < cacheCfgPkg::NUM_WAYS; w++) begin
      if (wayHit[w]) hitWay = cacheCfgPkg::wayT'(w);
    end
  end

  assign anyHit = |wayHit;
  assign selWay = (state == LOOKUP) ? hitWay : wayReg;

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      IDLE:      if (cpuReq.valid) nextState = LOOKUP;
      LOOKUP: begin
        if (anyHit) nextState = IDLE;
        else if (wayValid[victimWay] && wayDirty[victimWay]) nextState = WRITEBACK;
        else nextState = REFILL;
      end
      WRITEBACK: if (beatAcc && lastBeat) nextState = REFILL;
      REFILL:    if (beatAcc && lastBeat) nextState = COMPLETE;
      COMPLETE:  nextState = IDLE;
      default:   nextState = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge addr_ok) begin
    if (addr_ok) begin
      state   <= IDLE;
      beatCnt <= '0;
    end else begin
      state <= nextState;
      if (beatAcc) beatCnt <= cacheCfgPkg::wordSelT'(beatCnt + 1'b1);  // wraps per line
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && cpuReq.valid) req <= cpuReq;
    if (state == LOOKUP) wayReg <= victimWay;
  end

  ////////////////////////////////////////
  // array writes and ports
  ////////////////////////////////////////

  always_comb begin
    wordWrEn  = '0;
    markDirty = '0;
    installEn = '0;
    byteEn    = req.byteEn;
    wrData    = req.wdata;
    case (state)
      LOOKUP: begin
        if (anyHit && req.write) begin
          wordWrEn[hitWay]  = 1'b1;
          markDirty[hitWay] = 1'b1;
        end
      end
      REFILL: begin
        if (beatAcc) begin
          wordWrEn[wayReg]  = 1'b1;
          byteEn            = '1;
          wrData            = memResp.rdata;
          installEn[wayReg] = lastBeat;  // tag goes in with the last word
        end
      end
      COMPLETE: begin
        if (req.write) begin  // merge over the refilled line
          wordWrEn[wayReg]  = 1'b1;
          markDirty[wayReg] = 1'b1;
        end
      end
      default: ;
    endcase
  end

  assign touchEn  = (state == LOOKUP && anyHit) || (state == COMPLETE);
  assign touchWay = selWay;

  assign cpuResp.done  = touchEn;
  assign cpuResp.rdata = wayData[selWay];

  assign memReq.valid    = inXfer;
  assign memReq.write    = state == WRITEBACK;
  assign memReq.lineAddr = (state == WRITEBACK) ? {wayTags[wayReg], index}
                                                : {lookupTag, index};
  assign memReq.wdata    = wayData[wayReg];

endmodule

//--- logic/cacheTop.sv
`timescale 1ns/1ps

module cacheTop (
  input  logic                 clk,
  input  logic                 addr_ok,
  input  cacheBusPkg::cpuReqT  cpuReq,
  output cacheBusPkg::cpuRespT cpuResp,
  output cacheBusPkg::memReqT  memReq,
  input  cacheBusPkg::memRespT memResp
);

  cacheCfgPkg::indexT   index;
  cacheCfgPkg::tagT     lookupTag;
  cacheCfgPkg::wordSelT wordSel;
  cacheCfgPkg::byteEnT  byteEn;
  cacheCfgPkg::wordT    wrData;

  // per-way status and strobes
  cacheCfgPkg::wayVecT wayHit;
  cacheCfgPkg::wayVecT wayValid;
  cacheCfgPkg::wayVecT wayDirty;
  cacheCfgPkg::wayVecT wordWrEn;
  cacheCfgPkg::wayVecT markDirty;
  cacheCfgPkg::wayVecT installEn;
  cacheCfgPkg::tagT    wayTags [cacheCfgPkg::NUM_WAYS];
  cacheCfgPkg::wordT   wayData [cacheCfgPkg::NUM_WAYS];

  logic             touchEn;
  cacheCfgPkg::wayT touchWay;
  cacheCfgPkg::wayT victimWay;

  ////////////////////////////////////////
  // ways share index, tag and write data
  ////////////////////////////////////////

  for (genvar g = 0; g < cacheCfgPkg::NUM_WAYS; g++) begin : way_g
    wayStore way_i (
      .clk       (clk),
      .addr_ok   (addr_ok),
      .index     (index),
      .lookupTag (lookupTag),
      .wordSel   (wordSel),
      .wordWrEn  (wordWrEn[g]),
      .byteEn    (byteEn),
      .wrData    (wrData),
      .markDirty (markDirty[g]),
      .installEn (installEn[g]),
      .hit       (wayHit[g]),
      .lineValid (wayValid[g]),
      .lineDirty (wayDirty[g]),
      .storedTag (wayTags[g]),
      .rdata     (wayData[g])
    );
  end

  lruTracker lru_i (
    .clk       (clk),
    .addr_ok   (addr_ok),
    .index     (index),
    .wayValid  (wayValid),
    .touchEn   (touchEn),
    .touchWay  (touchWay),
    .victimWay (victimWay)
  );

  cacheCtrl ctrl_i (
    .clk       (clk),
    .addr_ok   (addr_ok),
    .cpuReq    (cpuReq),
    .cpuResp   (cpuResp),
    .memReq    (memReq),
    .memResp   (memResp),
    .index     (index),
    .lookupTag (lookupTag),
    .wordSel   (wordSel),
    .wayHit    (wayHit),
    .wayValid  (wayValid),
    .wayDirty  (wayDirty),
    .wayTags   (wayTags),
    .wayData   (wayData),
    .wordWrEn  (wordWrEn),
    .byteEn    (byteEn),
    .wrData    (wrData),
    .markDirty (markDirty),
    .installEn (installEn),
    .touchEn   (touchEn),
    .touchWay  (touchWay),
    .victimWay (victimWay)
  );

endmodule

//--- verification/cacheProps.sv
`timescale 1ns/1ps

module cacheProps (
  input logic                 clk,
  input logic                 addr_ok,
  input cacheBusPkg::cpuRespT cpuResp,
  input cacheBusPkg::memReqT  memReq,
  input cacheBusPkg::memRespT memResp
);

  ////////////////////////////////////////
  // memory port
  ////////////////////////////////////////

  // a stalled beat keeps all its fields
  memHold: assert property (@(posedge clk) disable iff (addr_ok)
    memReq.valid && !memResp.ready |=> $stable(memReq))
    else $error("memReq changed while waiting for ready");

  ////////////////////////////////////////
  // cpu port
  ////////////////////////////////////////

  donePulse: assert property (@(posedge clk) disable iff (addr_ok)
    cpuResp.done |=> !cpuResp.done)
    else $error("done high for two cycles in a row");

  doneQuiet: assert property (@(posedge clk) disable iff (addr_ok)
    cpuResp.done |-> !memReq.valid)  // no transfer in a done cycle
    else $error("memReq.valid high together with done");

endmodule

//--- verification/cacheTb.sv
`timescale 1ns/1ps

module cacheTb;

  typedef struct packed {
    logic                  isWrite;
    cacheCfgPkg::addrT     addr;
    cacheCfgPkg::wordT     data;
    cacheCfgPkg::byteEnT   byteEn;
    logic [1:0]            lines;   // lines moved, 2 means write-back plus refill
    cacheCfgPkg::lineAddrT wbLine;
  } stimT;

  localparam int TIMEOUT = 200;

  logic                 clk;
  logic                 addr_ok;
  cacheBusPkg::cpuReqT  cpuReq;
  cacheBusPkg::cpuRespT cpuResp;
  cacheBusPkg::memReqT  memReq;
  cacheBusPkg::memRespT memResp;

  // both keyed by word address
  cacheCfgPkg::wordT memWords [cacheCfgPkg::addrT];
  cacheCfgPkg::wordT shadow   [cacheCfgPkg::addrT];  // what the cpu should read back
  stimT              stimQ    [$];

  logic [31:0]           rngState;
  cacheCfgPkg::wordSelT  beat;
  int                    readBeats;
  int                    writeBeats;
  cacheCfgPkg::lineAddrT curLine;
  cacheCfgPkg::lineAddrT curWbLine;

  cacheTop dut_i (
    .clk     (clk),
    .addr_ok (addr_ok),
    .cpuReq  (cpuReq),
    .cpuResp (cpuResp),
    .memReq  (memReq),
    .memResp (memResp)
  );

  bind cacheTop cacheProps props_i (
    .clk     (clk),
    .addr_ok (addr_ok),
    .cpuResp (cpuResp),
    .memReq  (memReq),
    .memResp (memResp)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic cacheCfgPkg::wordT initWord(input cacheCfgPkg::addrT wa);
    return wa ^ 32'h5a5a_0000;
  endfunction

  function automatic cacheCfgPkg::wordT memRead(input cacheCfgPkg::addrT wa);
    return memWords.exists(wa) ? memWords[wa] : initWord(wa);
  endfunction

  function automatic cacheCfgPkg::wordT shadowRead(input cacheCfgPkg::addrT wa);
    return shadow.exists(wa) ? shadow[wa] : initWord(wa);
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkWord(input string name, input cacheCfgPkg::wordT got,
                           input cacheCfgPkg::wordT exp);
    if (got !== exp) abortRun($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic checkLineAddr(input string name, input cacheCfgPkg::lineAddrT got,
                               input cacheCfgPkg::lineAddrT exp);
    if (got !== exp) abortRun($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    if (got != exp) abortRun($sformatf("Fail %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic mergeShadow(input cacheCfgPkg::addrT addr, input cacheCfgPkg::wordT data,
                             input cacheCfgPkg::byteEnT be);
    cacheCfgPkg::addrT wa;
    cacheCfgPkg::wordT w;
    wa = {2'b00, addr[31:2]};
    w  = shadowRead(wa);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) w[8*b +: 8] = data[8*b +: 8];
    end
    shadow[wa] = w;
  endtask

  task automatic fillTable();
    // read miss, then hit in set 1
    stimQ.push_back(stimT'{1'b0, 32'h0000_0114, 32'h0, 4'h0, 2'd1, 28'h0});
    stimQ.push_back(stimT'{1'b0, 32'h0000_0118, 32'h0, 4'h0, 2'd0, 28'h0});
    // byte writes in set 2
    stimQ.push_back(stimT'{1'b0, 32'h0000_0220, 32'h0, 4'h0, 2'd1, 28'h0});
    stimQ.push_back(stimT'{1'b1, 32'h0000_0224, 32'hdead_beef, 4'b0101, 2'd0, 28'h0});
    stimQ.push_back(stimT'{1'b0, 32'h0000_0224, 32'h0, 4'h0, 2'd0, 28'h0});
    stimQ.push_back(stimT'{1'b1, 32'h0000_0328, 32'h1234_5678, 4'b1110, 2'd1, 28'h0});
    stimQ.push_back(stimT'{1'b0, 32'h0000_0328, 32'h0, 4'h0, 2'd0, 28'h0});
    stimQ.push_back(stimT'{1'b0, 32'h0000_032c, 32'h0, 4'h0, 2'd0, 28'h0});
    // dirty evictions in set 3
    stimQ.push_back(stimT'{1'b1, 32'h0000_1030, 32'h1111_0000, 4'hf, 2'd1, 28'h0});
    stimQ.push_back(stimT'{1'b1, 32'h0000_1134, 32'h2222_0001, 4'b0011, 2'd1, 28'h0});
    stimQ.push_back(stimT'{1'b1, 32'h0000_1238, 32'h3333_0002, 4'hf, 2'd1, 28'h0});
    stimQ.push_back(stimT'{1'b1, 32'h0000_133c, 32'h4444_0003, 4'b1000, 2'd1, 28'h0});
    stimQ.push_back(stimT'{1'b1, 32'h0000_1430, 32'h5555_0004, 4'hf, 2'd2, 28'h103});
    stimQ.push_back(stimT'{1'b0, 32'h0000_1030, 32'h0, 4'h0, 2'd2, 28'h113});
    stimQ.push_back(stimT'{1'b0, 32'h0000_1134, 32'h0, 4'h0, 2'd2, 28'h123});
    // lru order in set 4, E pushes out B
    stimQ.push_back(stimT'{1'b0, 32'h0000_2040, 32'h0, 4'h0, 2'd1, 28'h0});
    stimQ.push_back(stimT'{1'b0, 32'h0000_2140, 32'h0, 4'h0, 2'd1, 28'h0});
    stimQ.push_back(stimT'{1'b0, 32'h0000_2240, 32'h0, 4'h0, 2'd1, 28'h0});
    stimQ.push_back(stimT'{1'b0, 32'h0000_2340, 32'h0, 4'h0, 2'd1, 28'h0});
    stimQ.push_back(stimT'{1'b0, 32'h0000_2044, 32'h0, 4'h0, 2'd0, 28'h0});
    stimQ.push_back(stimT'{1'b0, 32'h0000_2440, 32'h0, 4'h0, 2'd1, 28'h0});
    stimQ.push_back(stimT'{1'b0, 32'h0000_2048, 32'h0, 4'h0, 2'd0, 28'h0});
    stimQ.push_back(stimT'{1'b0, 32'h0000_2140, 32'h0, 4'h0, 2'd1, 28'h0});
  endtask

  ////////////////////////////////////////
  // clock and memory model
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // sample mid-cycle, move the beat at the edge, drive 1 ns later
  initial begin
    cacheBusPkg::memReqT seen;
    logic                seenReady;
    cacheCfgPkg::addrT   wa;
    memResp  = '0;
    rngState = 32'hc12d_e5b7;
    beat     = '0;
    forever begin
      @(negedge clk);
      seen      = memReq;
      seenReady = memResp.ready;
      @(posedge clk);
      if (seen.valid && seenReady) begin
        wa = {2'b00, seen.lineAddr, beat};
        if (seen.write) begin
          $display("mem write line %h word %0d data %h", seen.lineAddr, beat, seen.wdata);
          if (readBeats != 0) abortRun("write-back beat seen after the refill had started");
          checkLineAddr("memReq.lineAddr", seen.lineAddr, curWbLine);
          checkWord("memReq.wdata", seen.wdata, shadowRead(wa));
          memWords[wa] = seen.wdata;
          writeBeats++;
        end else begin
          $display("mem read  line %h word %0d data %h", seen.lineAddr, beat, memResp.rdata);
          checkLineAddr("memReq.lineAddr", seen.lineAddr, curLine);
          readBeats++;
        end
        beat = beat + 1'b1;  // wraps per line
      end
      #1;
      rngState      = xorshift(rngState);
      memResp.ready = rngState[0];
      if (memReq.valid) begin
        wa            = {2'b00, memReq.lineAddr, beat};
        memResp.rdata = memRead(wa);
      end
    end
  end

  ////////////////////////////////////////
  // reset and stimulus
  ////////////////////////////////////////

  initial begin
    stimT                 e;
    cacheBusPkg::cpuRespT resp;
    int                   waited;
    addr_ok    = 1'b1;
    cpuReq     = '0;
    readBeats  = 0;
    writeBeats = 0;
    curLine    = '0;
    curWbLine  = '0;
    fillTable();
    repeat (10) begin
      @(negedge clk);
      checkCount("cpuResp.done", int'(cpuResp.done), 0);
      checkCount("memReq.valid", int'(memReq.valid), 0);
    end
    @(posedge clk);
    #1 addr_ok = 1'b0;
    repeat (2) begin
      @(negedge clk);
      checkCount("cpuResp.done", int'(cpuResp.done), 0);
      checkCount("memReq.valid", int'(memReq.valid), 0);
    end

    foreach (stimQ[i]) begin
      e = stimQ[i];
      @(posedge clk);
      #1;
      readBeats     = 0;
      writeBeats    = 0;
      curLine       = e.addr[31:4];
      curWbLine     = e.wbLine;
      cpuReq.valid  = 1'b1;
      cpuReq.write  = e.isWrite;
      cpuReq.addr   = e.addr;
      cpuReq.wdata  = e.data;
      cpuReq.byteEn = e.byteEn;
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
        resp = cpuResp;
      end while (!resp.done && waited < TIMEOUT);
      if (!resp.done) abortRun("no cpuResp.done within the timeout");
      // first negedge comes before the accepting edge
      if (e.lines == 2'd0) checkCount("cycles to done", waited - 1, 1);
      checkCount("memory beats", readBeats + writeBeats, 4 * int'(e.lines));
      checkCount("write-back beats", writeBeats, (e.lines == 2'd2) ? 4 : 0);
      if (e.isWrite) begin
        mergeShadow(e.addr, e.data, e.byteEn);
      end else begin
        checkWord("cpuResp.rdata", resp.rdata, shadowRead({2'b00, e.addr[31:2]}));
      end
    end

    @(posedge clk);
    #1 cpuReq = '0;
    repeat (4) @(posedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- vlog.f
common/cacheCfgPkg.sv
common/cacheBusPkg.sv
cacheArray/wayStore.sv
cacheArray/lruTracker.sv
logic/cacheCtrl.sv
logic/cacheTop.sv
verification/cacheProps.sv
verification/cacheTb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module cacheTb -f vlog.f -o cacheSim \
  && ./obj_dir/cacheSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTBENCH PASSED" sim.log \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
